//--- src.f
verilog/dpPkg.sv
verilog/aluIf.sv
verilog/registerFile.sv
verilog/busMux.sv
verilog/alu.sv
verilog/datapath.sv
bench/datapath_assertions.sv
bench/datapath_tb.sv

//--- bench/datapath_tb.sv
module datapath_tb;
  import dpPkg::*;

  localparam int XFER_COUNT = 8;
  localparam int ALU_COUNT = 200;
  localparam int OP_COUNT = XFER_COUNT + ALU_COUNT + 12;  // plus hi/lo, r0/r15, priority ops
  localparam int CYCLE_LIMIT = 12 * OP_COUNT + 100;

  logic [31:0] outPortData, busMuxOut, inPortDataIn, busMuxInPc, busMuxInMdr, cSignExtended;
  logic        clock, rst, yIn, hiIn, hiOut, loIn, loOut, zIn, zHighOut, zLowOut;
  logic        pcOut, mdrOut, inPortOut, cOut, incPc, inPortEn, outPortEn, baOut, jalR15;
  logic [4:0]  aluOpcode;
  logic [15:0] regIn, regOut;

  logic [31:0] lfsrState = 32'd7;
  logic        checkEn = 1'b0;
  logic        checkIsPort = 1'b0;
  logic [31:0] checkExp;
  logic [31:0] actual;
  string       checkWhat;
  string       testName;
  int          checkCount = 0;
  int          errorCount = 0;
  int          testErrors = 0;
  int          testCount = 0;
  int          badTests = 0;
  int          cycleCount = 0;

  datapath dut_i (.*);

  bind datapath datapathAssertions busChecks (
    .clock     (clock),
    .rst       (rst),
    .busMuxOut (busMuxOut),
    .srcOut    (srcOut),
    .baOut     (baOut),
    .zIn       (zIn),
    .zValue    (zQ)
  );

  always #2 clock = ~clock;

  // right-shift Galois LFSR
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsrState[0]};  // one step per bit
      lfsrState = lfsrNext(lfsrState);
    end
    return v;
  endfunction

  // expected 64-bit Z value
  function automatic logic [63:0] aluModel(input logic [4:0] op, input logic [31:0] y,
      input logic [31:0] b, input logic inc);
    logic        [31:0] low;
    logic signed [63:0] ys;
    logic signed [63:0] bs;
    logic signed [31:0] q;
    logic signed [31:0] r;
    int                 sh;
    low = '0;
    ys = $signed(y);
    bs = $signed(b);
    sh = b % 32;
    if (inc) return {32'h0, b + 32'd1};  // opcode ignored
    case (op)
      OP_ADD: low = y + b;
      OP_SUB: low = y - b;
      OP_AND: low = y & b;
      OP_OR: low = y | b;
      OP_SHR: low = y >> sh;
      OP_SHRA: low = $signed(y) >>> sh;
      OP_SHL: low = y << sh;
      OP_ROR: begin
        for (int i = 0; i < 32; i++) low[i] = y[(i + sh) % 32];
      end
      OP_ROL: begin
        for (int i = 0; i < 32; i++) low[(i + sh) % 32] = y[i];
      end
      OP_MUL: return ys * bs;
      OP_DIV: begin
        if (b == 32'h0) return {y, 32'hFFFF_FFFF};
        q = $signed(y) / $signed(b);
        r = $signed(y) % $signed(b);
        return {r, q};  // remainder high, quotient low
      end
      OP_NEG: low = -b;
      OP_NOT: low = ~b;
      default: low = '0;
    endcase
    return {32'h0, low};
  endfunction

  task automatic idleStrobes();
    yIn <= 1'b0;
    hiIn <= 1'b0;
    hiOut <= 1'b0;
    loIn <= 1'b0;
    loOut <= 1'b0;
    zIn <= 1'b0;
    zHighOut <= 1'b0;
    zLowOut <= 1'b0;
    pcOut <= 1'b0;
    mdrOut <= 1'b0;
    inPortOut <= 1'b0;
    cOut <= 1'b0;
    incPc <= 1'b0;
    aluOpcode <= 5'd0;
    inPortEn <= 1'b0;
    outPortEn <= 1'b0;
    regIn <= '0;
    regOut <= '0;
    baOut <= 1'b0;
    jalR15 <= 1'b0;
  endtask

  task automatic nextCycle();
    @(posedge clock);
    idleStrobes();
    checkEn = 1'b0;
  endtask

  // compared at the next falling edge
  task automatic armCheck(input logic isPort, input string what, input logic [31:0] exp);
    checkEn = 1'b1;
    checkIsPort = isPort;
    checkWhat = what;
    checkExp = exp;
  endtask

  task automatic loadInPort(input logic [31:0] w);
    nextCycle();
    inPortDataIn <= w;
    inPortEn <= 1'b1;
  endtask

  task automatic writeReg(input int k, input logic [31:0] w);
    loadInPort(w);
    nextCycle();
    inPortOut <= 1'b1;
    regIn <= 16'd1 << k;
  endtask

  task automatic runAlu(input logic [4:0] op, input logic inc, input logic [31:0] yVal,
      input logic [31:0] bVal, output logic [63:0] zExp);
    zExp = aluModel(op, yVal, bVal, inc);
    loadInPort(yVal);
    nextCycle();
    inPortOut <= 1'b1;
    yIn <= 1'b1;
    loadInPort(bVal);
    nextCycle();
    inPortOut <= 1'b1;
    zIn <= 1'b1;
    aluOpcode <= op;
    incPc <= inc;
    nextCycle();
    zLowOut <= 1'b1;
    armCheck(1'b0, "Z low", zExp[31:0]);
    nextCycle();
    zHighOut <= 1'b1;
    armCheck(1'b0, "Z high", zExp[63:32]);
  endtask

  task automatic moveZToHiLo(input logic [63:0] zExp);
    nextCycle();
    zHighOut <= 1'b1;
    hiIn <= 1'b1;
    nextCycle();
    zLowOut <= 1'b1;
    loIn <= 1'b1;
    nextCycle();
    hiOut <= 1'b1;
    armCheck(1'b0, "HI from Z high", zExp[63:32]);
    nextCycle();
    loOut <= 1'b1;
    armCheck(1'b0, "LO from Z low", zExp[31:0]);
  endtask

  task automatic beginTest(input string name);
    testName = name;
    testErrors = errorCount;
  endtask

  task automatic endTest();
    nextCycle();
    testCount++;
    if (errorCount != testErrors) begin
      badTests++;
      $display("test %s: %0d mismatches", testName, errorCount - testErrors);
    end else begin
      $display("test %s: ok", testName);
    end
  endtask

  always @(negedge clock) begin
    if (checkEn) begin
      checkCount++;
      actual = checkIsPort ? outPortData : busMuxOut;
      if (actual !== checkExp) begin
        errorCount++;
        $display("[FAIL] %s (%s): got 0x%h, expected 0x%h",
                 checkIsPort ? "outPortData" : "busMuxOut", checkWhat, actual, checkExp);
      end
    end
  end

  always @(posedge clock) begin
    cycleCount++;
    if (cycleCount >= CYCLE_LIMIT) begin
      $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] w, a, yVal, bVal, pcVal, mdrVal, immVal;
    logic [63:0] zExp;
    logic [4:0]  op;
    logic        inc;
    int          k;
    int          slot;
    clock = 1'b0;
    rst = 1'b1;
    inPortDataIn = '0;
    busMuxInPc = '0;
    busMuxInMdr = '0;
    cSignExtended = '0;
    idleStrobes();
    repeat (10) @(posedge clock);
    rst <= 1'b0;

    beginTest("reset_transfer");
    nextCycle();
    armCheck(1'b0, "idle bus after reset", '0);
    for (int i = 0; i < REG_COUNT; i++) begin
      nextCycle();
      regOut <= 16'd1 << i;
      armCheck(1'b0, "register after reset", '0);
    end
    nextCycle();
    hiOut <= 1'b1;
    armCheck(1'b0, "HI after reset", '0);
    nextCycle();
    loOut <= 1'b1;
    armCheck(1'b0, "LO after reset", '0);
    nextCycle();
    zHighOut <= 1'b1;
    armCheck(1'b0, "Z high after reset", '0);
    nextCycle();
    zLowOut <= 1'b1;
    armCheck(1'b0, "Z low after reset", '0);
    nextCycle();
    inPortOut <= 1'b1;
    armCheck(1'b0, "inport after reset", '0);
    nextCycle();
    armCheck(1'b1, "outport after reset", '0);
    for (int i = 0; i < XFER_COUNT; i++) begin
      k = randBits(4);
      w = randBits(32);
      writeReg(k, w);
      nextCycle();
      regOut <= 16'd1 << k;
      outPortEn <= 1'b1;
      armCheck(1'b0, "register readback", w);
      nextCycle();
      armCheck(1'b1, "register to outport", w);
    end
    endTest();

    beginTest("alu_ops");
    for (int i = 0; i < ALU_COUNT; i++) begin
      slot = i % 15;
      yVal = randBits(32);
      bVal = randBits(32);
      inc = 1'b0;
      if (slot < 13) begin
        op = 5'(slot);
      end else if (slot == 13) begin
        op = 5'd13 + 5'(randBits(4));  // unused code
      end else begin
        op = 5'(randBits(5));
        inc = 1'b1;
      end
      if (op == OP_DIV && (i % 4) == 0) bVal = '0;
      runAlu(op, inc, yVal, bVal, zExp);
    end
    endTest();

    beginTest("hi_lo");
    runAlu(OP_MUL, 1'b0, randBits(32), randBits(32), zExp);
    moveZToHiLo(zExp);
    runAlu(OP_DIV, 1'b0, randBits(32), randBits(16) + 32'd1, zExp);
    moveZToHiLo(zExp);
    endTest();

    beginTest("r0_r15");
    w = randBits(32) | 32'h1;  // never zero
    writeReg(0, w);
    nextCycle();
    regOut <= 16'h0001;
    baOut <= 1'b1;
    armCheck(1'b0, "R0 masked by baOut", '0);
    nextCycle();
    regOut <= 16'h0001;
    armCheck(1'b0, "R0 contents kept", w);
    w = randBits(32);
    loadInPort(w);
    nextCycle();
    inPortOut <= 1'b1;
    jalR15 <= 1'b1;
    nextCycle();
    regOut <= 16'h8000;
    armCheck(1'b0, "R15 loaded by jalR15", w);
    endTest();

    beginTest("bus_priority");
    a = randBits(32);
    w = randBits(32);
    pcVal = randBits(32);
    mdrVal = randBits(32);
    immVal = randBits(32);
    writeReg(3, a);
    writeReg(9, w);
    nextCycle();
    regOut <= 16'h0208;
    armCheck(1'b0, "R9 over R3", w);
    nextCycle();
    busMuxInPc <= pcVal;
    busMuxInMdr <= mdrVal;
    pcOut <= 1'b1;
    mdrOut <= 1'b1;
    armCheck(1'b0, "MDR over PC", mdrVal);
    nextCycle();
    cSignExtended <= immVal;
    regOut <= '1;
    hiOut <= 1'b1;
    loOut <= 1'b1;
    zHighOut <= 1'b1;
    zLowOut <= 1'b1;
    pcOut <= 1'b1;
    mdrOut <= 1'b1;
    inPortOut <= 1'b1;
    cOut <= 1'b1;
    armCheck(1'b0, "immediate over all sources", immVal);
    endTest();

    $display("tests run %0d, with mismatches %0d, checks %0d, errors %0d",
             testCount, badTests, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- bench/datapath_assertions.sv
module datapathAssertions (
  input logic                            clock,
  input logic                            rst,
  input logic [dpPkg::WORD_W-1:0]        busMuxOut,
  input logic [dpPkg::SRC_COUNT-1:0]     srcOut,
  input logic                            baOut,
  input logic                            zIn,
  input logic [2*dpPkg::WORD_W-1:0]      zValue
);
  import dpPkg::*;

  // nothing driving the bus
  idleBusZero: assert property (@(posedge clock) disable iff (rst)
    srcOut == '0 |-> busMuxOut == '0)
    else $error("bus is not zero while no out strobe is set");

  // R0 reads as zero for base address zero
  r0Masked: assert property (@(posedge clock) disable iff (rst)
    (srcOut[SRC_R0] && baOut && srcOut[SRC_COUNT-1:1] == '0) |-> busMuxOut == '0)
    else $error("R0 reached the bus while baOut was set");

  // Z only moves on zIn
  zHolds: assert property (@(posedge clock) disable iff (rst)
    !zIn |=> $stable(zValue))
    else $error("Z changed without zIn");

endmodule

//--- verilog/datapath.sv
module datapath (
  output logic [dpPkg::WORD_W-1:0]    outPortData,
  output logic [dpPkg::WORD_W-1:0]    busMuxOut,
  input  logic [dpPkg::WORD_W-1:0]    inPortDataIn,
  input  logic [dpPkg::WORD_W-1:0]    busMuxInPc,
  input  logic [dpPkg::WORD_W-1:0]    busMuxInMdr,
  input  logic [dpPkg::WORD_W-1:0]    cSignExtended,
  input  logic                        clock,
  input  logic                        rst,
  input  logic                        yIn,
  input  logic                        hiIn,
  input  logic                        hiOut,
  input  logic                        loIn,
  input  logic                        loOut,
  input  logic                        zIn,
  input  logic                        zHighOut,
  input  logic                        zLowOut,
  input  logic                        pcOut,
  input  logic                        mdrOut,
  input  logic                        inPortOut,
  input  logic                        cOut,
  input  logic                        incPc,
  input  logic [4:0]                  aluOpcode,
  input  logic                        inPortEn,
  input  logic                        outPortEn,
  input  logic [dpPkg::REG_COUNT-1:0] regIn,
  input  logic [dpPkg::REG_COUNT-1:0] regOut,
  input  logic                        baOut,
  input  logic                        jalR15
);
  import dpPkg::*;

  logic [REG_COUNT-1:0][WORD_W-1:0] regVal;
  logic [WORD_W-1:0]                hiQ;
  logic [WORD_W-1:0]                loQ;
  logic [WORD_W-1:0]                yQ;
  logic [WORD_W-1:0]                inPortQ;
  zResult_t                         zQ;
  logic [SRC_COUNT-1:0]             srcOut;
  logic [SRC_COUNT-1:0][WORD_W-1:0] srcVal;

  aluIf aluPort ();

  registerFile regFile (
    .clock  (clock),
    .rst    (rst),
    .regIn  (regIn),
    .jalR15 (jalR15),
    .baOut  (baOut),
    .busIn  (busMuxOut),
    .regVal (regVal)
  );

  // special registers, all loaded on the same edge as the register file
  always_ff @(posedge clock) begin
    if (rst) begin
      hiQ <= '0;
      loQ <= '0;
      yQ <= '0;
      zQ <= '0;
      inPortQ <= '0;
      outPortData <= '0;
    end else begin
      if (hiIn) hiQ <= busMuxOut;
      if (loIn) loQ <= busMuxOut;
      if (yIn) yQ <= busMuxOut;
      if (zIn) zQ <= aluPort.result;  // Z ignores the bus
      if (inPortEn) inPortQ <= inPortDataIn;
      if (outPortEn) outPortData <= busMuxOut;
    end
  end

  // strobe order follows busSrc_t
  assign srcOut = {cOut, inPortOut, mdrOut, pcOut, zLowOut, zHighOut, loOut, hiOut, regOut};

  always_comb begin
    srcVal[REG_COUNT-1:0] = regVal;
    srcVal[SRC_HI] = hiQ;
    srcVal[SRC_LO] = loQ;
    srcVal[SRC_ZHIGH] = zQ[2*WORD_W-1:WORD_W];
    srcVal[SRC_ZLOW] = zQ[WORD_W-1:0];
    srcVal[SRC_PC] = busMuxInPc;
    srcVal[SRC_MDR] = busMuxInMdr;
    srcVal[SRC_INPORT] = inPortQ;
    srcVal[SRC_CIMM] = cSignExtended;  // highest priority source
  end

  busMux bus (
    .srcOut (srcOut),
    .srcVal (srcVal),
    .busOut (busMuxOut)
  );

  // ALU sees Y and the live bus
  assign aluPort.y = yQ;
  assign aluPort.b = busMuxOut;
  assign aluPort.opcode = aluOp_t'(aluOpcode);
  assign aluPort.incPc = incPc;

  alu aluUnit (
    .aluBus (aluPort)
  );

endmodule

//--- verilog/alu.sv
module alu (
  aluIf.unit aluBus
);
  import dpPkg::*;

  logic        [WORD_W-1:0]         y;
  logic        [WORD_W-1:0]         b;
  logic signed [WORD_W-1:0]         ySigned;
  logic signed [WORD_W-1:0]         bSigned;
  logic signed [2*WORD_W-1:0]       ySext;
  logic signed [2*WORD_W-1:0]       bSext;
  logic        [$clog2(WORD_W)-1:0] shamt;
  logic        [2*WORD_W-1:0]       yTwice;
  logic        [2*WORD_W-1:0]       rorWide;
  logic        [2*WORD_W-1:0]       rolWide;
  zResult_t                         result;

  function automatic logic [2*WORD_W-1:0] zeroExt(input logic [WORD_W-1:0] w);
    return {{WORD_W{1'b0}}, w};
  endfunction

  assign y = aluBus.y;
  assign b = aluBus.b;
  assign ySigned = y;
  assign bSigned = b;
  assign ySext = ySigned;  // sign extended to 64
  assign bSext = bSigned;
  assign shamt = b[$clog2(WORD_W)-1:0];  // shift count is b mod 32

  // rotates come out of a doubled copy of y
  assign yTwice = {y, y};
  assign rorWide = yTwice >> shamt;
  assign rolWide = yTwice << shamt;

  always_comb begin
    result = '0;
    if (aluBus.incPc) begin
      result.product = zeroExt(b + 1'b1);  // PC increment wins over the opcode
    end else begin
      case (aluBus.opcode)
        OP_ADD: begin
          result.product = zeroExt(y + b);
        end
        OP_SUB: begin
          result.product = zeroExt(y - b);
        end
        OP_AND: begin
          result.product = zeroExt(y & b);
        end
        OP_OR: begin
          result.product = zeroExt(y | b);
        end
        OP_SHR: begin
          result.product = zeroExt(y >> shamt);
        end
        OP_SHRA: begin
          result.product = zeroExt(ySigned >>> shamt);
        end
        OP_SHL: begin
          result.product = zeroExt(y << shamt);
        end
        OP_ROR: begin
          result.product = zeroExt(rorWide[WORD_W-1:0]);
        end
        OP_ROL: begin
          result.product = zeroExt(rolWide[2*WORD_W-1:WORD_W]);
        end
        OP_MUL: begin
          result.product = ySext * bSext;  // full signed product
        end
        OP_DIV: begin
          if (b == '0) begin
            result.div.quotient = '1;  // divide by zero marker
            result.div.remainder = y;
          end else begin
            result.div.quotient = ySigned / bSigned;
            result.div.remainder = ySigned % bSigned;
          end
        end
        OP_NEG: begin
          result.product = zeroExt(-b);
        end
        OP_NOT: begin
          result.product = zeroExt(~b);
        end
        default: begin
          result = '0;
        end
      endcase
    end
  end

  assign aluBus.result = result;

endmodule

//--- verilog/busMux.sv
module busMux (
  input  logic [dpPkg::SRC_COUNT-1:0]                     srcOut,
  input  logic [dpPkg::SRC_COUNT-1:0][dpPkg::WORD_W-1:0] srcVal,
  output logic [dpPkg::WORD_W-1:0]                        busOut
);
  import dpPkg::*;

  busSrc_t sel;     // encoded source
  logic    anyOut;  // some strobe is set

  // priority encoder, later (higher) index overwrites earlier ones
  always_comb begin
    sel = SRC_R0;
    anyOut = 1'b0;
    for (int i = 0; i < SRC_COUNT; i++) begin
      if (srcOut[i]) begin
        sel = busSrc_t'(i);
        anyOut = 1'b1;
      end
    end
  end

  // idle bus reads zero
  assign busOut = anyOut ? srcVal[sel] : '0;

endmodule

//--- verilog/registerFile.sv
module registerFile (
  input  logic                                            clock,
  input  logic                                            rst,
  input  logic [dpPkg::REG_COUNT-1:0]                     regIn,
  input  logic                                            jalR15,
  input  logic                                            baOut,
  input  logic [dpPkg::WORD_W-1:0]                        busIn,
  output logic [dpPkg::REG_COUNT-1:0][dpPkg::WORD_W-1:0] regVal
);
  import dpPkg::*;

  logic [REG_COUNT-1:0][WORD_W-1:0] regQ;
  logic [REG_COUNT-1:0]             loadEn;

  // jal writes the return address into R15
  always_comb begin
    loadEn = regIn;
    loadEn[REG_COUNT-1] = regIn[REG_COUNT-1] | jalR15;
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      regQ <= '0;
    end else begin
      for (int i = 0; i < REG_COUNT; i++) begin
        if (loadEn[i]) begin
          regQ[i] <= busIn;  // every strobed register takes the bus
        end
      end
    end
  end

  // base address zero: R0 looks empty on the bus, contents are kept
  always_comb begin
    regVal = regQ;
    if (baOut) begin
      regVal[0] = '0;
    end
  end

endmodule

//--- verilog/aluIf.sv
interface aluIf;
  import dpPkg::*;

  logic [WORD_W-1:0] y;       // Y register
  logic [WORD_W-1:0] b;       // current bus value
  aluOp_t            opcode;
  logic              incPc;   // forces b + 1
  zResult_t          result;  // goes to Z

  // datapath side
  modport dp (
    output y, b, opcode, incPc,
    input  result
  );

  // ALU side, purely combinational
  modport unit (
    input  y, b, opcode, incPc,
    output result
  );

endinterface

//--- verilog/dpPkg.sv
package dpPkg;

  localparam int WORD_W    = 32;
  localparam int REG_COUNT = 16;
  localparam int SEL_W     = 5;
  localparam int SRC_COUNT = 24;  // sources actually wired onto the bus

  // unlisted codes fall through to a zero result
  typedef enum logic [4:0] {
    OP_ADD  = 5'd0,
    OP_SUB  = 5'd1,
    OP_AND  = 5'd2,
    OP_OR   = 5'd3,
    OP_SHR  = 5'd4,
    OP_SHRA = 5'd5,
    OP_SHL  = 5'd6,
    OP_ROR  = 5'd7,
    OP_ROL  = 5'd8,
    OP_MUL  = 5'd9,
    OP_DIV  = 5'd10,
    OP_NEG  = 5'd11,
    OP_NOT  = 5'd12
  } aluOp_t;

  typedef enum logic [SEL_W-1:0] {
    SRC_R[16],     // R0..R15 at 0..15
    SRC_HI,
    SRC_LO,
    SRC_ZHIGH,
    SRC_ZLOW,
    SRC_PC,
    SRC_MDR,
    SRC_INPORT,
    SRC_CIMM
  } busSrc_t;

  typedef struct packed {
    logic signed [WORD_W-1:0] remainder;  // upper word
    logic signed [WORD_W-1:0] quotient;   // lower word
  } divResult_t;

  typedef union packed {
    logic signed [2*WORD_W-1:0] product;
    divResult_t                 div;
  } zResult_t;

endpackage
